/* lsu_pkg.sv */
// Load/store unit shared definitions
// Widths, RV32 encodings, instruction views and byte-lane helpers
package lsu_pkg;

    // Data path and register index widths
    localparam int xlen       = 32;
    localparam int strb_w     = xlen / 8;
    localparam int reg_addr_w = 5;

    // RV32 major opcodes handled by the unit
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

    // Access size codes, shared by LOAD and STORE
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    // AxCACHE values for device bufferable and normal non-cacheable bufferable
    localparam logic [3:0] cache_device = 4'b0001;
    localparam logic [3:0] cache_normal = 4'b0011;

    // Raw instruction word with an I-type view for loads and an S-type view for stores
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s_view;
    } inst_u;

    // Place store data on its byte lanes and build the matching strobe
    function automatic void store_lanes(
        input  logic [xlen-1:0]   data,
        input  logic [2:0]        funct3,
        input  logic [1:0]        offset,
        output logic [xlen-1:0]   lane_data,
        output logic [strb_w-1:0] lane_strb
    );
        lane_data = data << {offset, 3'b000};
        case (funct3)
            f3_b:    lane_strb = 4'b0001 << offset;
            f3_h:    lane_strb = 4'b0011 << offset;
            default: lane_strb = 4'b1111;
        endcase
    endfunction

    // Pull the addressed bytes down to bit 0, then sign or zero extend
    function automatic logic [xlen-1:0] load_extract(
        input logic [xlen-1:0] word,
        input logic [2:0]      funct3,
        input logic [1:0]      offset
    );
        logic [xlen-1:0] shifted;
        shifted = word >> {offset, 3'b000};
        case (funct3)
            f3_b:    return {{(xlen-8){shifted[7]}}, shifted[7:0]};
            f3_h:    return {{(xlen-16){shifted[15]}}, shifted[15:0]};
            f3_bu:   return {{(xlen-8){1'b0}}, shifted[7:0]};
            f3_hu:   return {{(xlen-16){1'b0}}, shifted[15:0]};
            default: return shifted;
        endcase
    endfunction

endpackage

/* lsu_agu.sv */
// Load/store address generation
// Effective address, alignment checks, store lanes and cache attribute
`timescale 1ns/1ps

module lsu_agu import lsu_pkg::*; #(
    parameter logic [xlen-1:0] IO_BASE = 32'h0010_0000,
    parameter logic [xlen-1:0] IO_LAST = 32'h0010_00ff
) (
    input  inst_u              inst,
    input  logic [xlen-1:0]    rs1_val,
    input  logic [xlen-1:0]    rs2_val,
    output logic [xlen-1:0]    addr,
    output logic               is_load,
    output logic               is_store,
    output logic               load_misaligned,
    output logic               store_misaligned,
    output logic [xlen-1:0]    wdata,
    output logic [strb_w-1:0]  wstrb,
    output logic [3:0]         cache
);

    logic [11:0] imm12;
    logic [2:0]  funct3;
    logic        size_misaligned;
    logic        io_hit;

    ////////////////////////////////////////////////////////////
    // Decode and effective address
    ////////////////////////////////////////////////////////////

    // Opcode and funct3 sit at the same place in both views
    assign is_load  = inst.i_view.opcode == opc_load;
    assign is_store = inst.s_view.opcode == opc_store;
    assign funct3   = inst.i_view.funct3;

    // S-type splits its immediate around rd
    assign imm12 = is_store ? {inst.s_view.imm_hi, inst.s_view.imm_lo}
                            : inst.i_view.imm;

    assign addr = rs1_val + {{(xlen-12){imm12[11]}}, imm12};

    ////////////////////////////////////////////////////////////
    // Alignment
    ////////////////////////////////////////////////////////////

    // Halfwords need an even offset, words a zero offset
    always_comb begin
        case (funct3)
            f3_h, f3_hu: size_misaligned = addr[0];
            f3_w:        size_misaligned = addr[1:0] != 2'b00;
            default:     size_misaligned = 1'b0;
        endcase
    end

    assign load_misaligned  = is_load & size_misaligned;
    assign store_misaligned = is_store & size_misaligned;

    // Store data shifted onto the lanes of the addressed word
    always_comb begin
        store_lanes(rs2_val, funct3, addr[1:0], wdata, wstrb);
    end

    ////////////////////////////////////////////////////////////
    // Memory attribute
    ////////////////////////////////////////////////////////////

    // IO window is device memory, everything else normal
    assign io_hit = (addr >= IO_BASE) && (addr <= IO_LAST);
    assign cache  = io_hit ? cache_device : cache_normal;

endmodule

/* lsu_issue_fsm.sv */
// Load/store issue FSM
// Drives AW, W and AR under the single-ID ordering rule between directions
`timescale 1ns/1ps

module lsu_issue_fsm import lsu_pkg::*; (
    input  logic               aclk,
    input  logic               aresetn,
    // Instruction side
    input  logic               inst_valid,
    output logic               inst_ready,
    input  logic [xlen-1:0]    addr,
    input  logic               is_load,
    input  logic               is_store,
    input  logic               load_misaligned,
    input  logic               store_misaligned,
    input  logic [xlen-1:0]    wdata,
    input  logic [strb_w-1:0]  wstrb,
    input  logic [3:0]         cache,
    // Tracking state
    input  logic               pending_read,
    input  logic               pending_write,
    input  logic               rd_full,
    input  logic               wr_full,
    input  logic               fifo_full,
    output logic               issue_rd,
    output logic               issue_wr,
    // AXI4-lite request channels
    output logic               awvalid,
    input  logic               awready,
    output logic [xlen-1:0]    awaddr,
    output logic [3:0]         awcache,
    output logic               wvalid,
    input  logic               wready,
    output logic [xlen-1:0]    wdata_o,
    output logic [strb_w-1:0]  wstrb_o,
    output logic               arvalid,
    input  logic               arready,
    output logic [xlen-1:0]    araddr,
    output logic [3:0]         arcache
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_wait  = 2'd1;
    localparam logic [1:0] st_serve = 2'd2;

    logic [1:0]      state;
    logic            store_q;
    logic            accept;
    logic            blocked;
    logic            bus_done;
    logic [xlen-1:0] addr_q;
    logic [3:0]      cache_q;

    ////////////////////////////////////////////////////////////
    // Acceptance
    ////////////////////////////////////////////////////////////

    // No room for another request in the instruction's direction
    assign blocked = fifo_full | (is_load & rd_full) | (is_store & wr_full);

    assign inst_ready = (state == st_idle) & ~blocked;
    assign accept     = inst_valid & inst_ready;

    // Misaligned accesses retire here without a bus request
    assign issue_rd = accept & is_load & ~load_misaligned;
    assign issue_wr = accept & is_store & ~store_misaligned;

    // Every raised channel is gone after this edge
    assign bus_done = (~awvalid | awready) & (~wvalid | wready) & (~arvalid | arready);

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            // Serve with nothing raised, so idle comes on the first edge
            state   <= st_serve;
            store_q <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (issue_rd || issue_wr) begin
                        store_q <= issue_wr;
                        // Other direction still owes completions
                        if ((issue_rd && pending_write) || (issue_wr && pending_read)) begin
                            state <= st_wait;
                        end else begin
                            arvalid <= issue_rd;
                            awvalid <= issue_wr;
                            wvalid  <= issue_wr;
                            state   <= st_serve;
                        end
                    end
                end
                st_wait: begin
                    if (store_q ? !pending_read : !pending_write) begin
                        arvalid <= !store_q;
                        awvalid <= store_q;
                        wvalid  <= store_q;
                        state   <= st_serve;
                    end
                end
                default: begin
                    // AW and W drop on their own handshakes
                    if (awready) awvalid <= 1'b0;
                    if (wready)  wvalid  <= 1'b0;
                    if (arready) arvalid <= 1'b0;
                    if (bus_done) state <= st_idle;
                end
            endcase
        end
    end

    // Request payload captured at acceptance and frozen until idle
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q  <= {addr[xlen-1:2], 2'b00};
            cache_q <= cache;
            wdata_o <= wdata;
            wstrb_o <= wstrb;
        end
    end

    assign awaddr  = addr_q;
    assign araddr  = addr_q;
    assign awcache = cache_q;
    assign arcache = cache_q;

endmodule

/* lsu_outstanding.sv */
// Outstanding request tracking
// Per-direction counters with limit and pending flags
`timescale 1ns/1ps

module lsu_outstanding #(
    parameter int MAX_OR = 4
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic issue_rd,
    input  logic issue_wr,
    input  logic bvalid,
    input  logic rvalid,
    output logic pending_read,
    output logic pending_write,
    output logic rd_full,
    output logic wr_full
);

    localparam int cnt_w = $clog2(MAX_OR + 1);

    // Index 0 is read, index 1 is write
    logic [1:0]            inc;
    logic [1:0]            dec;
    logic [1:0]            full;
    logic [1:0]            pend;
    logic [1:0][cnt_w-1:0] cnt;

    assign inc = {issue_wr, issue_rd};
    assign dec = {bvalid, rvalid};

    for (genvar i = 0; i < 2; i++) begin : g_dir
        // Issue and completion together leave the count alone
        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                cnt[i] <= '0;
            end else if (inc[i] && !dec[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end else if (dec[i] && !inc[i]) begin
                cnt[i] <= cnt[i] - 1'b1;
            end
        end

        assign full[i] = cnt[i] == cnt_w'(MAX_OR);
        // Last completion arriving now already clears the flag
        assign pend[i] = (cnt[i] != '0) && !((cnt[i] == cnt_w'(1)) && dec[i]);
    end

    assign pending_read  = pend[0];
    assign pending_write = pend[1];
    assign rd_full       = full[0];
    assign wr_full       = full[1];

endmodule

/* lsu_load_return.sv */
// Load return path
// Tracks load context in issue order and aligns read data for rd
`timescale 1ns/1ps

module lsu_load_return import lsu_pkg::*; #(
    parameter int MAX_OR = 4
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   issue_rd,
    input  logic [reg_addr_w-1:0]  rd,
    input  logic [2:0]             funct3,
    input  logic [1:0]             offset,
    input  logic                   rvalid,
    input  logic [xlen-1:0]        rdata,
    output logic                   fifo_full,
    output logic                   rd_wr,
    output logic [reg_addr_w-1:0]  rd_addr,
    output logic [xlen-1:0]        rd_val
);

    localparam int ptr_w = (MAX_OR > 1) ? $clog2(MAX_OR) : 1;
    localparam int cnt_w = $clog2(MAX_OR + 1);
    localparam int ctx_w = reg_addr_w + 5;

    // Context entry is {rd, funct3, offset}
    logic [ctx_w-1:0] ctx_mem [MAX_OR];
    logic [ctx_w-1:0] head;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    ////////////////////////////////////////////////////////////
    // Tracking FIFO
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (issue_rd) ctx_mem[wr_ptr] <= {rd, funct3, offset};
    end

    // Pointers wrap at MAX_OR, which need not be a power of two
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (issue_rd) wr_ptr <= (wr_ptr == ptr_w'(MAX_OR - 1)) ? '0 : wr_ptr + 1'b1;
            if (rvalid)   rd_ptr <= (rd_ptr == ptr_w'(MAX_OR - 1)) ? '0 : rd_ptr + 1'b1;
            if (issue_rd && !rvalid) count <= count + 1'b1;
            else if (rvalid && !issue_rd) count <= count - 1'b1;
        end
    end

    assign fifo_full = count == cnt_w'(MAX_OR);
    assign head      = ctx_mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Register write
    ////////////////////////////////////////////////////////////

    // Completions always accepted, so each beat writes rd at once
    assign rd_wr   = rvalid;
    assign rd_addr = head[ctx_w-1 -: reg_addr_w];
    assign rd_val  = load_extract(rdata, head[4:2], head[1:0]);

endmodule

/* lsu_top.sv */
// Load/store unit top level
// RV32 LOAD/STORE to AXI4-lite master with in-order completions
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
    parameter int              MAX_OR  = 4,
    parameter logic [xlen-1:0] IO_BASE = 32'h0010_0000,
    parameter logic [xlen-1:0] IO_LAST = 32'h0010_00ff
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    // Instruction side
    input  logic                   inst_valid,
    output logic                   inst_ready,
    input  inst_u                  inst,
    input  logic [xlen-1:0]        rs1_val,
    input  logic [xlen-1:0]        rs2_val,
    output logic                   pending_read,
    output logic                   pending_write,
    // Exceptions
    output logic                   exc_load_misaligned,
    output logic                   exc_store_misaligned,
    output logic [xlen-1:0]        exc_addr,
    // Register write port
    output logic                   rd_wr,
    output logic [reg_addr_w-1:0]  rd_addr,
    output logic [xlen-1:0]        rd_val,
    // AXI4-lite master
    output logic                   awvalid,
    input  logic                   awready,
    output logic [xlen-1:0]        awaddr,
    output logic [3:0]             awcache,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [xlen-1:0]        wdata,
    output logic [strb_w-1:0]      wstrb,
    input  logic                   bvalid,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [xlen-1:0]        araddr,
    output logic [3:0]             arcache,
    input  logic                   rvalid,
    input  logic [xlen-1:0]        rdata
);

    logic [xlen-1:0]   addr;
    logic              is_load;
    logic              is_store;
    logic              load_misaligned;
    logic              store_misaligned;
    logic [xlen-1:0]   lane_data;
    logic [strb_w-1:0] lane_strb;
    logic [3:0]        cache;
    logic              issue_rd;
    logic              issue_wr;
    logic              rd_full;
    logic              wr_full;
    logic              fifo_full;

    // Exceptions only in the cycle the instruction is taken
    assign exc_load_misaligned  = load_misaligned & inst_valid & inst_ready;
    assign exc_store_misaligned = store_misaligned & inst_valid & inst_ready;
    assign exc_addr             = addr;

    lsu_agu #(
        .IO_BASE (IO_BASE),
        .IO_LAST (IO_LAST)
    ) u_agu (
        .inst (inst), .rs1_val (rs1_val), .rs2_val (rs2_val),
        .addr (addr), .is_load (is_load), .is_store (is_store),
        .load_misaligned (load_misaligned), .store_misaligned (store_misaligned),
        .wdata (lane_data), .wstrb (lane_strb), .cache (cache)
    );

    lsu_issue_fsm u_issue (
        .aclk (aclk), .aresetn (aresetn),
        .inst_valid (inst_valid), .inst_ready (inst_ready),
        .addr (addr), .is_load (is_load), .is_store (is_store),
        .load_misaligned (load_misaligned), .store_misaligned (store_misaligned),
        .wdata (lane_data), .wstrb (lane_strb), .cache (cache),
        .pending_read (pending_read), .pending_write (pending_write),
        .rd_full (rd_full), .wr_full (wr_full), .fifo_full (fifo_full),
        .issue_rd (issue_rd), .issue_wr (issue_wr),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awcache (awcache),
        .wvalid (wvalid), .wready (wready), .wdata_o (wdata), .wstrb_o (wstrb),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arcache (arcache)
    );

    lsu_outstanding #(
        .MAX_OR (MAX_OR)
    ) u_outstanding (
        .aclk (aclk), .aresetn (aresetn),
        .issue_rd (issue_rd), .issue_wr (issue_wr),
        .bvalid (bvalid), .rvalid (rvalid),
        .pending_read (pending_read), .pending_write (pending_write),
        .rd_full (rd_full), .wr_full (wr_full)
    );

    // Load context comes from the I-type view
    lsu_load_return #(
        .MAX_OR (MAX_OR)
    ) u_load_return (
        .aclk (aclk), .aresetn (aresetn),
        .issue_rd (issue_rd), .rd (inst.i_view.rd),
        .funct3 (inst.i_view.funct3), .offset (addr[1:0]),
        .rvalid (rvalid), .rdata (rdata), .fifo_full (fifo_full),
        .rd_wr (rd_wr), .rd_addr (rd_addr), .rd_val (rd_val)
    );

endmodule

/* lsu_properties.sv */
// Load/store unit bus properties
// AXI4-lite request stability and single-ID ordering between directions
`timescale 1ns/1ps

module lsu_properties import lsu_pkg::*; (
    input logic              aclk,
    input logic              aresetn,
    input logic              awvalid,
    input logic              awready,
    input logic [xlen-1:0]   awaddr,
    input logic [3:0]        awcache,
    input logic              wvalid,
    input logic              wready,
    input logic [xlen-1:0]   wdata,
    input logic [strb_w-1:0] wstrb,
    input logic              arvalid,
    input logic              arready,
    input logic [xlen-1:0]   araddr,
    input logic [3:0]        arcache,
    input logic              pending_read,
    input logic              pending_write
);

    // Valid holds with its payload until ready
    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arcache))
        else $error("AR dropped or changed before arready");
    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awcache))
        else $error("AW dropped or changed before awready");
    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("W dropped or changed before wready");

    // A direction starts only once the other one has all its completions
    ar_order: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(arvalid) |-> !pending_write)
        else $error("arvalid rose with writes still pending");
    aw_order: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(awvalid) |-> !pending_read)
        else $error("awvalid rose with reads still pending");

endmodule

bind lsu_top lsu_properties u_properties (.*);

/* tb_lsu.sv */
// Load/store unit testbench
// Random LOAD/STORE stream against an AXI4-lite slave model and a reference model
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

    localparam int          max_or   = 4;
    localparam logic [31:0] io_base  = 32'h0010_0000;
    localparam logic [31:0] io_last  = 32'h0010_00ff;
    localparam int          n_inst   = 400;
    localparam int          max_wait = 1000;

    logic aclk;
    logic aresetn;
    logic inst_valid;
    logic inst_ready;
    logic [31:0] inst_w;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic pending_read, pending_write, exc_load_misaligned, exc_store_misaligned;
    logic [31:0] exc_addr;
    logic rd_wr;
    logic [4:0] rd_addr;
    logic [31:0] rd_val;
    logic awvalid, awready, wvalid, wready, bvalid, arvalid, arready, rvalid;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0] awcache, arcache, wstrb;

    // Reference model, slave model and expected request queues
    logic [31:0] rng;
    logic [31:0] ref_mem [256];
    logic [31:0] slv_mem [256];
    logic [35:0] aw_exp [$];
    logic [35:0] ar_exp [$];
    logic [35:0] w_exp [$];
    logic [36:0] ld_exp [$];
    logic [31:0] aw_slv [$];
    logic [35:0] w_slv [$];
    logic [31:0] r_slv [$];
    int b_slv, rd_cnt, wr_cnt, errors, n_gen, n_acc, n_ld, n_st, n_mis, waited;
    logic took;
    // Instruction currently on the bus as the generator built it
    logic cur_load;
    logic [2:0] cur_f3;
    logic [31:0] cur_addr;
    logic [4:0] cur_rd;

    lsu_top #(.MAX_OR (max_or), .IO_BASE (io_base), .IO_LAST (io_last)) uut (
        .aclk (aclk), .aresetn (aresetn),
        .inst_valid (inst_valid), .inst_ready (inst_ready), .inst (inst_w),
        .rs1_val (rs1_val), .rs2_val (rs2_val),
        .pending_read (pending_read), .pending_write (pending_write),
        .exc_load_misaligned (exc_load_misaligned),
        .exc_store_misaligned (exc_store_misaligned), .exc_addr (exc_addr),
        .rd_wr (rd_wr), .rd_addr (rd_addr), .rd_val (rd_val),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awcache (awcache),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .arvalid (arvalid), .arready (arready),
        .araddr (araddr), .arcache (arcache), .rvalid (rvalid), .rdata (rdata)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    ////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Normal words 0..63, IO window words 64..127
    function automatic logic [7:0] mem_index(input logic [31:0] a);
        return {1'b0, a[20], a[7:2]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] i);
        return {i, ~i, i ^ 8'h5a, i + 8'h33};
    endfunction

    // Stores only use b, h and w
    function automatic logic [2:0] pick_funct3(input logic store, input logic [2:0] sel);
        case (sel)
            3'd0, 3'd5: return f3_b;
            3'd1, 3'd6: return f3_h;
            3'd3:       return store ? f3_w : f3_bu;
            3'd4:       return store ? f3_b : f3_hu;
            default:    return f3_w;
        endcase
    endfunction

    function automatic logic misaligned(input logic [2:0] f3, input logic [1:0] off);
        case (f3)
            f3_h, f3_hu: return off[0];
            f3_w:        return off != 2'b00;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] strobe_of(input logic [2:0] f3, input logic [1:0] off);
        case (f3)
            f3_b:    return 4'b0001 << off;
            f3_h:    return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] w, input logic [2:0] f3,
                                                input logic [1:0] off);
        logic [31:0] s;
        s = w >> {off, 3'b000};
        case (f3)
            f3_b:    return {{24{s[7]}}, s[7:0]};
            f3_h:    return {{16{s[15]}}, s[15:0]};
            f3_bu:   return {24'h0, s[7:0]};
            f3_hu:   return {16'h0, s[15:0]};
            default: return s;
        endcase
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("error @ %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_inst();
        logic [31:0] r;
        logic [31:0] r3;
        logic [11:0] imm;
        logic [1:0]  off;
        // Held until the DUT takes it
        if (inst_valid && !took) return;
        took = 1'b0;
        r = rand32();
        if (n_gen >= n_inst || r[2:0] == 3'd0) begin
            inst_valid = 1'b0;
            return;
        end
        r3 = rand32();
        cur_load = !r[3];
        cur_f3 = pick_funct3(r[3], r[6:4]);
        // Mostly aligned, now and then any offset
        if (r[9:7] == 3'd0) off = r[11:10];
        else if (cur_f3 == f3_w) off = 2'b00;
        else if (cur_f3 == f3_h || cur_f3 == f3_hu) off = {r[10], 1'b0};
        else off = r[11:10];
        cur_addr = (r[13:12] == 2'b00 ? io_base : 32'h0) + {24'h0, r[19:14], off};
        imm = r[31:20];
        cur_rd = r3[14:10];
        rs1_val = cur_addr - {{20{imm[11]}}, imm};
        rs2_val = rand32();
        if (cur_load) inst_w = {imm, r3[9:5], cur_f3, cur_rd, opc_load};
        else inst_w = {imm[11:5], r3[4:0], r3[9:5], cur_f3, imm[4:0], opc_store};
        inst_valid = 1'b1;
        n_gen++;
    endtask

    // Random ready back-pressure and random response delays
    task automatic drive_slave();
        logic [31:0] r;
        r = rand32();
        awready = r[1:0] != 2'b00;
        wready  = r[3:2] != 2'b00;
        arready = r[5:4] != 2'b00;
        bvalid  = (b_slv > 0) && r[7:6] == 2'b00;
        rvalid  = (r_slv.size() > 0) && r[9:8] == 2'b00;
        rdata   = rvalid ? r_slv[0] : r;
    endtask

    ////////////////////////////////////////////////////////////
    // Checks sampled late in the cycle
    ////////////////////////////////////////////////////////////

    task automatic sample_outputs();
        logic        acc;
        logic        mis;
        logic [7:0]  i;
        logic [3:0]  strb;
        logic [31:0] word;
        logic [35:0] e;
        logic [36:0] ld;
        acc = inst_valid && inst_ready;
        mis = acc && misaligned(cur_f3, cur_addr[1:0]);
        // Flags come from counts before this cycle's updates
        if (pending_read != (rd_cnt != 0 && !(rd_cnt == 1 && rvalid)))
            log_error($sformatf("pending_read %0b with %0d loads open", pending_read, rd_cnt));
        if (pending_write != (wr_cnt != 0 && !(wr_cnt == 1 && bvalid)))
            log_error($sformatf("pending_write %0b with %0d stores open", pending_write, wr_cnt));
        if (exc_load_misaligned != (mis && cur_load) || exc_store_misaligned != (mis && !cur_load))
            log_error($sformatf("exception flags %0b%0b, misaligned %0b",
                exc_load_misaligned, exc_store_misaligned, mis));
        else if (mis && exc_addr != cur_addr)
            log_error($sformatf("exc_addr %h, expected %h", exc_addr, cur_addr));
        if (acc) begin
            took = 1'b1;
            n_acc++;
            waited = 0;
            i = mem_index(cur_addr);
            e = {(cur_addr >= io_base && cur_addr <= io_last) ? cache_device : cache_normal,
                 cur_addr[31:2], 2'b00};
            if (mis) begin
                n_mis++;
            end else if (cur_load) begin
                n_ld++;
                ar_exp.push_back(e);
                ld_exp.push_back({cur_rd, extend_load(ref_mem[i], cur_f3, cur_addr[1:0])});
                rd_cnt++;
            end else begin
                n_st++;
                strb = strobe_of(cur_f3, cur_addr[1:0]);
                word = rs2_val << {cur_addr[1:0], 3'b000};
                aw_exp.push_back(e);
                w_exp.push_back({strb, word});
                ref_mem[i] = (ref_mem[i] & ~byte_mask(strb)) | (word & byte_mask(strb));
                wr_cnt++;
            end
        end else begin
            waited++;
        end
        if (awvalid && awready) begin
            if (aw_exp.size() == 0) log_error("AW handshake without an issued store");
            else if ({awcache, awaddr} != aw_exp[0])
                log_error($sformatf("AW %h/%h, expected %h", awcache, awaddr, aw_exp[0]));
            if (aw_exp.size() > 0) void'(aw_exp.pop_front());
            aw_slv.push_back(awaddr);
        end
        if (wvalid && wready) begin
            if (w_exp.size() == 0) begin
                log_error("W handshake without an issued store");
            end else begin
                e = w_exp.pop_front();
                if (wstrb != e[35:32] || (wdata & byte_mask(wstrb)) != (e[31:0] & byte_mask(wstrb)))
                    log_error($sformatf("W %h/%h, expected %h", wstrb, wdata, e));
            end
            w_slv.push_back({wstrb, wdata});
        end
        if (arvalid && arready) begin
            if (ar_exp.size() == 0) log_error("AR handshake without an issued load");
            else if ({arcache, araddr} != ar_exp[0])
                log_error($sformatf("AR %h/%h, expected %h", arcache, araddr, ar_exp[0]));
            if (ar_exp.size() > 0) void'(ar_exp.pop_front());
            r_slv.push_back(slv_mem[mem_index(araddr)]);
        end
        // Slave commits a write once address and data have both arrived
        if (aw_slv.size() > 0 && w_slv.size() > 0) begin
            e = w_slv.pop_front();
            i = mem_index(aw_slv.pop_front());
            slv_mem[i] = (slv_mem[i] & ~byte_mask(e[35:32])) | (e[31:0] & byte_mask(e[35:32]));
            b_slv++;
        end
        if (bvalid) begin
            b_slv--;
            wr_cnt--;
        end
        if (rd_wr != rvalid) log_error($sformatf("rd_wr %0b with rvalid %0b", rd_wr, rvalid));
        if (rvalid) begin
            void'(r_slv.pop_front());
            rd_cnt--;
            if (ld_exp.size() == 0) begin
                log_error("read response with no load outstanding");
            end else begin
                ld = ld_exp.pop_front();
                if (rd_addr != ld[36:32] || rd_val != ld[31:0])
                    log_error($sformatf("rd x%0d = %h, expected x%0d = %h",
                        rd_addr, rd_val, ld[36:32], ld[31:0]));
            end
        end
        if (rd_cnt > max_or || wr_cnt > max_or)
            log_error($sformatf("%0d reads and %0d writes open", rd_cnt, wr_cnt));
    endtask

    task automatic cycle();
        @(posedge aclk);
        #1;
        drive_slave();
        drive_inst();
        #5;
        sample_outputs();
    endtask

    initial begin
        rng = 32'h3fa3_2738;
        aresetn = 1'b0;
        inst_valid = 1'b0;
        inst_w = '0;
        rs1_val = '0;
        rs2_val = '0;
        awready = 1'b0;
        wready = 1'b0;
        arready = 1'b0;
        bvalid = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        took = 1'b0;
        {b_slv, rd_cnt, wr_cnt, errors, n_gen, n_acc, n_ld, n_st, n_mis, waited} = '0;
        for (int k = 0; k < 256; k++) begin
            ref_mem[k] = fill_word(8'(k));
            slv_mem[k] = fill_word(8'(k));
        end
        repeat (16) @(posedge aclk);
        #1 aresetn = 1'b1;
        while (n_acc < n_inst && waited < max_wait) cycle();
        // Drain outstanding responses before the verdict
        if (waited < max_wait) begin
            waited = 0;
            while ((rd_cnt > 0 || wr_cnt > 0 || awvalid || wvalid || arvalid)
                   && waited < max_wait) cycle();
        end
        if (waited >= max_wait)
            $display("timeout: the LSU made no progress for %0d cycles", max_wait);
        $display("loads %0d, stores %0d, misaligned %0d, errors %0d", n_ld, n_st, n_mis, errors);
        if (errors == 0 && waited < max_wait) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
lsu_pkg.sv
lsu_agu.sv
lsu_issue_fsm.sv
lsu_outstanding.sv
lsu_load_return.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f flist.f -o tb_lsu_sim \
    && ./obj_dir/tb_lsu_sim | tee /dev/stderr | grep -qF "Simulation finished: PASS" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
